// File: hw/rom_cfg_pkg.sv
/* Sizes for the ROM side: address and data widths, store depth
   and refresh timing */
`default_nettype none

package rom_cfg_pkg;

    // Download side, one byte per address
    localparam int byte_addr_w = 13;
    localparam int byte_w      = 8;

    // Word store side, two byte lanes per word
    localparam int word_addr_w = 12;
    localparam int word_w      = 16;
    localparam int mask_w      = word_w / byte_w;
    localparam int store_depth = 4096;

    // Refresh slot timing in clk_rom cycles
    localparam int refresh_period = 64;
    localparam int refresh_cycles = 4;

    // Counter wide enough for the longer of the two intervals
    localparam int refresh_cnt_w  = $clog2(refresh_period);

endpackage

`default_nettype wire

// File: hw/rom_types_pkg.sv
/* Payload structs for download bytes, program writes,
   game read requests and read responses */
`default_nettype none

package rom_types_pkg;

    // One byte from the I/O controller
    typedef struct packed {
        logic [rom_cfg_pkg::byte_addr_w-1:0] addr;
        logic [rom_cfg_pkg::byte_w-1:0]      data;
        logic                                last;  // Final byte of the download
    } ioctl_byte_t;

    // Half-word write into the store
    typedef struct packed {
        logic [rom_cfg_pkg::word_addr_w-1:0] addr;
        logic [rom_cfg_pkg::byte_w-1:0]      data;
        logic [rom_cfg_pkg::mask_w-1:0]      mask;  // Bit 1 selects the high lane
    } prog_word_t;

    // Game read
    typedef struct packed {
        logic [rom_cfg_pkg::word_addr_w-1:0] addr;
    } rom_req_t;

    // Read answer, tagged with the address it belongs to
    typedef struct packed {
        logic [rom_cfg_pkg::word_w-1:0]      data;
        logic [rom_cfg_pkg::word_addr_w-1:0] addr;
    } rom_rsp_t;

endpackage

`default_nettype wire

// File: hw/hs_stage.sv
/* Single-entry valid/ready register stage, payload given by type */
`timescale 1ns/1ns
`default_nettype none

module hs_stage #(
    parameter type payload_t = logic
) (
    input  wire logic     clk_rom,
    input  wire logic     rst_n,

    input  wire payload_t in_data,
    input  wire logic     in_valid,
    output      logic     in_ready,

    output      payload_t out_data,
    output      logic     out_valid,
    input  wire logic     out_ready
);

    logic full;
    logic in_fire;

    // Room when empty, or when the entry leaves this cycle
    assign in_ready  = !full || out_ready;
    assign in_fire   = in_valid && in_ready;
    assign out_valid = full;

    always_ff @(posedge clk_rom) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (in_fire) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0;   // Drained with nothing behind it
        end
    end

    always_ff @(posedge clk_rom) begin
        if (in_fire) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/prog_packer.sv
/* Download byte to masked half-word write, plus the downloading flag */
`timescale 1ns/1ns
`default_nettype none

module prog_packer (
    input  wire logic                      clk_rom,
    input  wire logic                      rst_n,

    // Byte stream from the I/O controller
    input  wire rom_types_pkg::ioctl_byte_t byte_in,
    input  wire logic                      byte_valid,
    output      logic                      byte_ready,

    // Word writes towards the store
    output      rom_types_pkg::prog_word_t word_out,
    output      logic                      word_valid,
    input  wire logic                      word_ready,

    output      logic                      downloading
);

    logic byte_fire;

    assign byte_fire  = byte_valid && byte_ready;

    // Pure pass-through handshake, no buffering here
    assign word_valid = byte_valid;
    assign byte_ready = word_ready;

    always_comb begin
        word_out.addr = byte_in.addr[rom_cfg_pkg::byte_addr_w-1:1];  // Byte to word address
        word_out.data = byte_in.data;
        // Even bytes go to the low lane, odd bytes to the high lane
        word_out.mask = {byte_in.addr[0], ~byte_in.addr[0]};
    end

    // Set by any accepted byte, cleared by the one flagged last
    always_ff @(posedge clk_rom) begin
        if (!rst_n) begin
            downloading <= 1'b0;
        end else if (byte_fire) begin
            downloading <= !byte_in.last;
        end
    end

endmodule

`default_nettype wire

// File: hw/refresh_timer.sv
/* Refresh period counter and refresh slot timer */
`timescale 1ns/1ns
`default_nettype none

module refresh_timer (
    input  wire logic clk_rom,
    input  wire logic rst_n,
    input  wire logic refresh_start,
    output      logic refresh_due,
    output      logic refresh_busy
);

    logic [rom_cfg_pkg::refresh_cnt_w-1:0] cnt;

    // Same counter times the gap and then the slot itself
    always_ff @(posedge clk_rom) begin
        if (!rst_n) begin
            cnt          <= '0;
            refresh_due  <= 1'b0;
            refresh_busy <= 1'b0;
        end else if (refresh_busy) begin
            if (cnt == rom_cfg_pkg::refresh_cnt_w'(rom_cfg_pkg::refresh_cycles - 1)) begin
                refresh_busy <= 1'b0;
                cnt          <= '0;     // Next period starts here
            end else begin
                cnt <= cnt + 1'b1;
            end
        end else if (refresh_due) begin
            // Waits here until the FSM grants the slot
            if (refresh_start) begin
                refresh_due  <= 1'b0;
                refresh_busy <= 1'b1;
                cnt          <= '0;
            end
        end else if (cnt == rom_cfg_pkg::refresh_cnt_w'(rom_cfg_pkg::refresh_period - 1)) begin
            refresh_due <= 1'b1;
            cnt         <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/rom_access_fsm.sv
/* Access FSM sharing the word store between download writes,
   refresh slots and game reads */
`timescale 1ns/1ns
`default_nettype none

module rom_access_fsm (
    input  wire logic                                  clk_rom,
    input  wire logic                                  rst_n,

    // Program writes from the download path
    input  wire rom_types_pkg::prog_word_t             prog,
    input  wire logic                                  prog_valid,
    output      logic                                  prog_ready,
    input  wire logic                                  downloading,

    // Game reads
    input  wire rom_types_pkg::rom_req_t               req,
    input  wire logic                                  req_valid,
    output      logic                                  req_ready,
    output      rom_types_pkg::rom_rsp_t               rsp,
    output      logic                                  rsp_valid,
    input  wire logic                                  rsp_ready,

    // Refresh timer
    input  wire logic                                  refresh_due,
    input  wire logic                                  refresh_busy,
    output      logic                                  refresh_start,

    // Word store port
    output      logic                                  store_we,
    output      logic [rom_cfg_pkg::mask_w-1:0]        store_mask,
    output      logic [rom_cfg_pkg::word_addr_w-1:0]   store_addr,
    output      logic [rom_cfg_pkg::word_w-1:0]        store_wdata,
    input  wire logic [rom_cfg_pkg::word_w-1:0]        store_rdata
);

    typedef enum logic [2:0] {
        st_idle,
        st_write,
        st_refresh,
        st_read,
        st_respond
    } state_t;

    state_t                              state, state_nxt;
    logic [rom_cfg_pkg::word_addr_w-1:0] rd_addr;   // Address of the read in flight
    logic                                req_fire;

    // Reads only from idle with nothing of higher priority waiting
    assign req_ready = (state == st_idle) && !prog_valid && !refresh_due
                       && !downloading && rsp_ready;
    assign req_fire  = req_valid && req_ready;

    assign refresh_start = (state == st_idle) && !prog_valid && refresh_due;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (prog_valid)       state_nxt = st_write;
                else if (refresh_due) state_nxt = st_refresh;
                else if (req_fire)    state_nxt = st_read;
            end
            st_write:   state_nxt = st_idle;    // Single-cycle write
            st_refresh: if (!refresh_busy) state_nxt = st_idle;
            st_read:    state_nxt = st_respond; // Store output registers here
            st_respond: if (rsp_ready) state_nxt = st_idle;
            default:    state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk_rom) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk_rom) begin
        if (req_fire) begin
            rd_addr <= req.addr;
        end
    end

    // Store port steering
    assign prog_ready  = (state == st_write);
    assign store_we    = (state == st_write);
    assign store_mask  = prog.mask;
    assign store_wdata = {prog.data, prog.data};  // Mask picks the lane
    // Holding rd_addr keeps rdata stable while the response stalls
    assign store_addr  = (state == st_write) ? prog.addr : rd_addr;

    assign rsp_valid = (state == st_respond);
    assign rsp.data  = store_rdata;
    assign rsp.addr  = rd_addr;

endmodule

`default_nettype wire

// File: hw/word_store.sv
/* On-chip word store with byte-lane write mask and registered read */
`timescale 1ns/1ns
`default_nettype none

module word_store (
    input  wire logic                                clk_rom,
    input  wire logic                                we,
    input  wire logic [rom_cfg_pkg::mask_w-1:0]      mask,
    input  wire logic [rom_cfg_pkg::word_addr_w-1:0] addr,
    input  wire logic [rom_cfg_pkg::word_w-1:0]      wdata,
    output      logic [rom_cfg_pkg::word_w-1:0]      rdata
);

    logic [rom_cfg_pkg::word_w-1:0] mem [rom_cfg_pkg::store_depth];

    always_ff @(posedge clk_rom) begin
        if (we) begin
            for (int i = 0; i < rom_cfg_pkg::mask_w; i++) begin
                // Untouched lane keeps its old byte
                if (mask[i]) begin
                    mem[addr][i*rom_cfg_pkg::byte_w +: rom_cfg_pkg::byte_w] <=
                        wdata[i*rom_cfg_pkg::byte_w +: rom_cfg_pkg::byte_w];
                end
            end
        end
    end

    // Read data one cycle after the address
    always_ff @(posedge clk_rom) begin
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// File: hw/rom_board_top.sv
/* ROM side of the board: packer, handshake stages, refresh timer,
   access FSM and word store */
`timescale 1ns/1ns
`default_nettype none

module rom_board_top (
    input  wire logic                       clk_rom,
    input  wire logic                       rst_n,

    input  wire rom_types_pkg::ioctl_byte_t byte_in,
    input  wire logic                       byte_valid,
    output      logic                       byte_ready,

    input  wire rom_types_pkg::rom_req_t    req,
    input  wire logic                       req_valid,
    output      logic                       req_ready,
    output      rom_types_pkg::rom_rsp_t    rsp,
    output      logic                       rsp_valid,
    input  wire logic                       rsp_ready,

    output      logic                       downloading
);

    rom_types_pkg::prog_word_t           pk_word, prog_word;
    logic                                pk_valid, pk_ready;
    logic                                prog_valid, prog_ready;
    rom_types_pkg::rom_rsp_t             fsm_rsp;
    logic                                fsm_rsp_valid, fsm_rsp_ready;
    logic                                refresh_due, refresh_busy, refresh_start;
    logic                                store_we;
    logic [rom_cfg_pkg::mask_w-1:0]      store_mask;
    logic [rom_cfg_pkg::word_addr_w-1:0] store_addr;
    logic [rom_cfg_pkg::word_w-1:0]      store_wdata, store_rdata;

    prog_packer u_packer (
        .clk_rom     ( clk_rom     ),
        .rst_n       ( rst_n       ),
        .byte_in     ( byte_in     ),
        .byte_valid  ( byte_valid  ),
        .byte_ready  ( byte_ready  ),
        .word_out    ( pk_word     ),
        .word_valid  ( pk_valid    ),
        .word_ready  ( pk_ready    ),
        .downloading ( downloading )
    );

    hs_stage #(.payload_t(rom_types_pkg::prog_word_t)) u_prog_stage (
        .clk_rom   ( clk_rom    ),
        .rst_n     ( rst_n      ),
        .in_data   ( pk_word    ),
        .in_valid  ( pk_valid   ),
        .in_ready  ( pk_ready   ),
        .out_data  ( prog_word  ),
        .out_valid ( prog_valid ),
        .out_ready ( prog_ready )
    );

    refresh_timer u_refresh (
        .clk_rom       ( clk_rom       ),
        .rst_n         ( rst_n         ),
        .refresh_start ( refresh_start ),
        .refresh_due   ( refresh_due   ),
        .refresh_busy  ( refresh_busy  )
    );

    rom_access_fsm u_fsm (
        .clk_rom       ( clk_rom       ),
        .rst_n         ( rst_n         ),
        .prog          ( prog_word     ),
        .prog_valid    ( prog_valid    ),
        .prog_ready    ( prog_ready    ),
        .downloading   ( downloading   ),
        .req           ( req           ),
        .req_valid     ( req_valid     ),
        .req_ready     ( req_ready     ),
        .rsp           ( fsm_rsp       ),
        .rsp_valid     ( fsm_rsp_valid ),
        .rsp_ready     ( fsm_rsp_ready ),
        .refresh_due   ( refresh_due   ),
        .refresh_busy  ( refresh_busy  ),
        .refresh_start ( refresh_start ),
        .store_we      ( store_we      ),
        .store_mask    ( store_mask    ),
        .store_addr    ( store_addr    ),
        .store_wdata   ( store_wdata   ),
        .store_rdata   ( store_rdata   )
    );

    hs_stage #(.payload_t(rom_types_pkg::rom_rsp_t)) u_rsp_stage (
        .clk_rom   ( clk_rom       ),
        .rst_n     ( rst_n         ),
        .in_data   ( fsm_rsp       ),
        .in_valid  ( fsm_rsp_valid ),
        .in_ready  ( fsm_rsp_ready ),
        .out_data  ( rsp           ),
        .out_valid ( rsp_valid     ),
        .out_ready ( rsp_ready     )
    );

    word_store u_store (
        .clk_rom ( clk_rom     ),
        .we      ( store_we    ),
        .mask    ( store_mask  ),
        .addr    ( store_addr  ),
        .wdata   ( store_wdata ),
        .rdata   ( store_rdata )
    );

endmodule

`default_nettype wire

// File: dv/rom_board_tb_util.svh
/* LFSR random source and typed compare tasks for the ROM board testbench */
`ifndef ROM_BOARD_TB_UTIL_SVH
`define ROM_BOARD_TB_UTIL_SVH

logic [31:0] lfsr_state;

// Right-shifting Galois LFSR, toggle mask 32'h80200003
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One LFSR step per bit handed out
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

task automatic check_rsp(input rom_types_pkg::rom_rsp_t got,
                         input rom_types_pkg::rom_rsp_t want);
    if (got.addr !== want.addr) begin
        $display("MISMATCH rsp.addr got %h exp %h", got.addr, want.addr);
        halt_with_failure();
    end else if (got.data !== want.data) begin
        $display("MISMATCH rsp.data got %h exp %h at word %h", got.data, want.data, want.addr);
        halt_with_failure();
    end
endtask

task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
        $display("MISMATCH %s got %h exp %h", name, got, want);
        halt_with_failure();
    end
endtask

`endif

// File: dv/rom_board_tb.sv
/* Testbench for the ROM board: random download and read traffic
   checked against a reference word memory */
`timescale 1ns/1ns
`default_nettype none

module rom_board_tb;

    localparam int dl_bytes       = 256;
    localparam int odd_bytes      = dl_bytes / 2;
    localparam int dl_words       = dl_bytes / 2;
    localparam int bp_reads       = 200;
    localparam int burst_reads    = 600;
    localparam int total_reads    = 2 * dl_words + bp_reads + burst_reads;
    localparam int timeout_cycles = dl_bytes + odd_bytes + 20 * total_reads + 200;

    logic                       clk_rom;
    logic                       rst_n;
    rom_types_pkg::ioctl_byte_t byte_in;
    logic                       byte_valid, byte_ready;
    rom_types_pkg::rom_req_t    req;
    logic                       req_valid, req_ready;
    rom_types_pkg::rom_rsp_t    rsp;
    logic                       rsp_valid, rsp_ready;
    logic                       downloading;

    logic [rom_cfg_pkg::word_w-1:0]      ref_mem [rom_cfg_pkg::store_depth];
    rom_types_pkg::ioctl_byte_t          byte_q[$];   // Bytes still to send
    logic [rom_cfg_pkg::word_addr_w-1:0] req_q[$];    // Reads still to issue
    rom_types_pkg::rom_rsp_t             exp_q[$];    // Expected responses, oldest first
    logic                                dl_exp, byte_taken, req_taken, heavy_bp, req_gaps;
    int                                  cycle_cnt, base_byte;

    rom_board_top rom_board_top_inst (
        .clk_rom     ( clk_rom     ),
        .rst_n       ( rst_n       ),
        .byte_in     ( byte_in     ),
        .byte_valid  ( byte_valid  ),
        .byte_ready  ( byte_ready  ),
        .req         ( req         ),
        .req_valid   ( req_valid   ),
        .req_ready   ( req_ready   ),
        .rsp         ( rsp         ),
        .rsp_valid   ( rsp_valid   ),
        .rsp_ready   ( rsp_ready   ),
        .downloading ( downloading )
    );

    task automatic halt_with_failure();
        $display("sim failed");
        $fatal(1);
    endtask

    `include "rom_board_tb_util.svh"

    initial begin
        clk_rom = 1'b0;
        forever #5 clk_rom = ~clk_rom;
    end

    task automatic queue_download(input int first, input int step, input int count);
        rom_types_pkg::ioctl_byte_t b;
        logic [31:0]                bits, a32;
        for (int i = 0; i < count; i++) begin
            bits   = take_bits(rom_cfg_pkg::byte_w);
            a32    = first + i * step;
            b.addr = a32[rom_cfg_pkg::byte_addr_w-1:0];
            b.data = bits[rom_cfg_pkg::byte_w-1:0];
            b.last = (i == count - 1);
            byte_q.push_back(b);
        end
    endtask

    task automatic queue_reads(input int word_base, input int count, input logic random_addr);
        logic [31:0] bits, a32;
        for (int i = 0; i < count; i++) begin
            if (random_addr) begin
                bits = take_bits(7);                // Anywhere in the written window
                a32  = word_base + int'(bits[6:0]);
            end else begin
                a32  = word_base + i;
            end
            req_q.push_back(a32[rom_cfg_pkg::word_addr_w-1:0]);
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] bits;
        bits = take_bits(6);
        if (byte_taken) byte_valid = 1'b0;
        if (req_taken) req_valid = 1'b0;
        byte_taken = 1'b0;
        req_taken  = 1'b0;
        if (!byte_valid && byte_q.size() != 0 && bits[1:0] != 2'b00) begin
            byte_in    = byte_q[0];
            byte_valid = 1'b1;
        end
        if (!req_valid && req_q.size() != 0 && (!req_gaps || bits[3:2] != 2'b00)) begin
            req.addr  = req_q[0];
            req_valid = 1'b1;
        end
        rsp_ready = heavy_bp ? bits[4] : (bits[5:4] != 2'b00);
    endtask

    // Called mid-cycle, so every handshake seen here completes on the next edge
    task automatic sample_outputs();
        rom_types_pkg::rom_rsp_t             want;
        logic [rom_cfg_pkg::word_addr_w-1:0] w;
        check_flag("downloading", downloading, dl_exp);
        if (req_ready && downloading) begin
            $display("ERROR: req_ready high while a download is in progress");
            halt_with_failure();
        end
        if (rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: response for word %h with no read outstanding", rsp.addr);
                halt_with_failure();
            end else begin
                check_rsp(rsp, exp_q.pop_front());
            end
        end
        if (byte_valid && byte_ready) begin
            // Word address is the byte address over two, bit 0 picks the lane
            w = byte_in.addr[rom_cfg_pkg::byte_addr_w-1:1];
            if (byte_in.addr[0]) ref_mem[w][15:8] = byte_in.data;
            else ref_mem[w][7:0] = byte_in.data;
            dl_exp     = !byte_in.last;
            byte_taken = 1'b1;
            void'(byte_q.pop_front());
        end
        if (req_valid && req_ready) begin
            want.data = ref_mem[req.addr];
            want.addr = req.addr;
            exp_q.push_back(want);
            req_taken = 1'b1;
            void'(req_q.pop_front());
        end
    endtask

    task automatic run_cycle();
        @(posedge clk_rom);
        #1;
        drive_inputs();
        @(negedge clk_rom);
        sample_outputs();
        cycle_cnt++;
        if (cycle_cnt > timeout_cycles) begin
            $display("ERROR: timeout after %0d cycles with %0d bytes, %0d reads, %0d responses left",
                     cycle_cnt, byte_q.size(), req_q.size(), exp_q.size());
            halt_with_failure();
        end
    endtask

    task automatic run_until_drained();
        while (byte_q.size() != 0 || req_q.size() != 0 || exp_q.size() != 0) begin
            run_cycle();
        end
    endtask

    initial begin
        logic [31:0] bits;
        rst_n      = 1'b0;
        byte_in    = '0;
        byte_valid = 1'b0;
        req        = '0;
        req_valid  = 1'b0;
        rsp_ready  = 1'b0;
        lfsr_state = 32'h75dc;
        dl_exp     = 1'b0;
        byte_taken = 1'b0;
        req_taken  = 1'b0;
        heavy_bp   = 1'b0;
        req_gaps   = 1'b1;
        cycle_cnt  = 0;
        repeat (10) @(posedge clk_rom);
        #1;
        rst_n = 1'b1;
        @(negedge clk_rom);
        check_flag("rsp_valid", rsp_valid, 1'b0);
        check_flag("downloading", downloading, 1'b0);

        bits      = take_bits(4);
        base_byte = int'(bits[3:0]) * 512;     // Random 512-byte window
        queue_download(base_byte, 1, dl_bytes);
        run_until_drained();
        queue_reads(base_byte / 2, dl_words, 1'b0);
        run_until_drained();

        heavy_bp = 1'b1;                       // Response side stalls half the time
        queue_reads(base_byte / 2, bp_reads, 1'b1);
        run_until_drained();

        heavy_bp = 1'b0;
        req_gaps = 1'b0;                       // Back-to-back requests over many refresh slots
        queue_reads(base_byte / 2, burst_reads, 1'b1);
        run_until_drained();

        // Odd bytes only, low lanes must keep the first download
        req_gaps = 1'b1;
        queue_download(base_byte + 1, 2, odd_bytes);
        run_until_drained();
        queue_reads(base_byte / 2, dl_words, 1'b0);
        run_until_drained();

        repeat (20) run_cycle();               // Any extra response shows up here
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+dv
hw/rom_cfg_pkg.sv
hw/rom_types_pkg.sv
hw/hs_stage.sv
hw/prog_packer.sv
hw/refresh_timer.sv
hw/rom_access_fsm.sv
hw/word_store.sv
hw/rom_board_top.sv
dv/rom_board_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and decide the result from the simulation output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module rom_board_tb -f flist.f \
    && ./obj_dir/Vrom_board_tb | tee /dev/stderr | grep -qx "sim passed" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
